/* sim.f */
logic/eng_cfg_pkg.sv
logic/eng_types_pkg.sv
logic/cfg_fsm.sv
logic/addr_counter.sv
logic/coef_ram.sv
logic/lrelu_lane.sv
logic/lrelu_engine.sv
sim/lrelu_engine_sva.sv
sim/lrelu_engine_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module lrelu_engine_tb; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vlrelu_engine_tb 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Simulation PASSED" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

/* sim/lrelu_engine_tb.sv */
`timescale 1ns/1ps

module lrelu_engine_tb;

  // three loads, about 300 beats with idle gaps and drains need well under 1000
  localparam int MAX_CYCLES = 4000;

  typedef struct packed {
    logic                      is_max;
    eng_types_pkg::lanes_out_t data;
  } exp_beat_t;

  logic                          clk;
  logic                          rst_n;
  logic                          cfg_valid;
  logic [eng_cfg_pkg::CFG_W-1:0] cfg_data;
  logic                          cfg_1x1;
  logic                          s_valid;
  eng_types_pkg::lanes_in_t      s_data;
  eng_types_pkg::beat_flags_t    s_flags;
  logic                          m_valid;
  eng_types_pkg::lanes_out_t     m_data;
  logic                          m_is_max;

  integer    seed;
  int        cycles;
  exp_beat_t exp_q[$];

  // reference copy of the loaded tables
  logic signed [15:0] model_a [eng_cfg_pkg::DEPTH_1X1];
  logic signed [15:0] model_b [eng_cfg_pkg::DEPTH_1X1];
  logic signed [15:0] model_d;
  int                 model_depth;
  int                 rd_idx;   // channel index of the next beat

  lrelu_engine lrelu_engine_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_valid (cfg_valid),
    .cfg_data  (cfg_data),
    .cfg_1x1   (cfg_1x1),
    .s_valid   (s_valid),
    .s_data    (s_data),
    .s_flags   (s_flags),
    .m_valid   (m_valid),
    .m_data    (m_data),
    .m_is_max  (m_is_max)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // value in -(span-1)..span-1
  function automatic int rand_span(input int span);
    rand_span = $random(seed) % span;
  endfunction

  function automatic logic [7:0] lane_model(input logic signed [15:0] x,
                                            input logic signed [15:0] a,
                                            input logic signed [15:0] b,
                                            input logic signed [15:0] d,
                                            input logic leak);
    longint p;
    longint s;
    p = longint'(x) * longint'(a) + longint'(b);
    if (leak && p < 0) begin
      p = (p * longint'(eng_cfg_pkg::ALPHA_NUM)) >>> eng_cfg_pkg::ALPHA_SHIFT;
    end
    s = (p + longint'(d)) >>> eng_cfg_pkg::OUT_SHIFT;
    if (s > 127) begin
      s = 127;
    end else if (s < -128) begin
      s = -128;
    end
    lane_model = 8'(s);
  endfunction

  // D, then the A words, then the B words, back to back
  task automatic load_config(input logic is_1x1, input int a_span);
    int depth;
    depth = is_1x1 ? int'(eng_cfg_pkg::DEPTH_1X1) : int'(eng_cfg_pkg::DEPTH_3X3);
    model_d = 16'(rand_span(1024));
    for (int i = 0; i < depth; i++) begin
      model_a[i] = 16'(rand_span(a_span));
      model_b[i] = 16'(rand_span(4096));
    end
    @(posedge clk);
    cfg_valid <= 1'b1;
    cfg_1x1   <= is_1x1;
    cfg_data  <= model_d;
    for (int i = 0; i < depth; i++) begin
      @(posedge clk);
      cfg_data <= model_a[i];
    end
    for (int i = 0; i < depth; i++) begin
      @(posedge clk);
      cfg_data <= model_b[i];
    end
    @(posedge clk);
    cfg_valid   <= 1'b0;
    model_depth = depth;
    rd_idx      = 0;   // D word restarts the channel index
  endtask

  task automatic run_beats(input int count, input int x_span);
    int                         sent;
    eng_types_pkg::lanes_in_t   x;
    eng_types_pkg::beat_flags_t f;
    exp_beat_t                  e;
    sent = 0;
    while (sent < count) begin
      @(posedge clk);
      if (($random(seed) & 3) == 0) begin
        s_valid <= 1'b0;   // idle cycle between bursts
      end else begin
        f = 2'($random(seed));
        for (int u = 0; u < eng_cfg_pkg::UNITS; u++) begin
          x[u] = 16'(rand_span(x_span));
          e.data[u] = lane_model(x[u], model_a[rd_idx], model_b[rd_idx], model_d,
                                 f.is_lrelu);
        end
        e.is_max = f.is_max;
        exp_q.push_back(e);
        s_valid <= 1'b1;
        s_data  <= x;
        s_flags <= f;
        rd_idx  = (rd_idx == model_depth - 1) ? 0 : rd_idx + 1;
        sent++;
      end
    end
    @(posedge clk);
    s_valid <= 1'b0;
  endtask

  // no new load while beats are still in flight
  task automatic drain;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation FAILED");
      $fatal(1, "timeout");
    end
  end

  // outputs are stable at the falling edge
  always @(negedge clk) begin : monitor
    exp_beat_t e;
    if (m_valid) begin
      if (exp_q.size() == 0) begin
        $display("m_valid went high at %0t with no beat outstanding", $time);
        $display("Simulation FAILED");
        $fatal(1, "unexpected output beat");
      end else begin
        e = exp_q.pop_front();
        check_equal(32'(m_data), 32'(e.data), "lane data");
        check_equal(32'(m_is_max), 32'(e.is_max), "is_max flag");
      end
    end
  end

  initial begin
    seed        = 32'h45b6;
    cycles      = 0;
    model_depth = int'(eng_cfg_pkg::DEPTH_1X1);
    rd_idx      = 0;
    rst_n       = 1'b0;
    cfg_valid   = 1'b0;
    cfg_data    = '0;
    cfg_1x1     = 1'b1;
    s_valid     = 1'b0;
    s_data      = '0;
    s_flags     = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    repeat (6) @(posedge clk);   // quiet output before any beat

    load_config(1'b1, 128);      // 1x1, moderate values, mix of leak and clamp
    run_beats(200, 512);
    drain();

    load_config(1'b0, 128);      // 3x3, index wraps at 2
    run_beats(60, 512);
    drain();

    load_config(1'b1, 32768);    // full range, drives the clamp both ways
    run_beats(40, 32768);
    drain();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* sim/lrelu_engine_sva.sv */
`timescale 1ns/1ps

module lrelu_engine_sva (
  input logic clk,
  input logic rst_n,
  input logic s_valid,
  input logic m_valid,
  input logic d_we,
  input logic a_we,
  input logic b_we
);

  // every accepted beat comes out LATENCY cycles later
  assert property (@(posedge clk) disable iff (!rst_n)
    s_valid |-> ##(eng_cfg_pkg::LATENCY) m_valid)
    else $error("m_valid missing after an accepted beat");

  // and nothing comes out without a beat
  assert property (@(posedge clk) disable iff (!rst_n)
    m_valid |-> $past(s_valid, eng_cfg_pkg::LATENCY))
    else $error("m_valid without a beat LATENCY cycles earlier");

  assert property (@(posedge clk) !rst_n |-> !m_valid)
    else $error("m_valid high during reset");

  assert property (@(posedge clk) $onehot0({d_we, a_we, b_we}))
    else $error("more than one table write enable");

endmodule

bind lrelu_engine lrelu_engine_sva sva_i (
  .clk     (clk),
  .rst_n   (rst_n),
  .s_valid (s_valid),
  .m_valid (m_valid),
  .d_we    (d_we),
  .a_we    (a_we),
  .b_we    (b_we)
);

/* logic/lrelu_engine.sv */
`timescale 1ns/1ps

module lrelu_engine (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              cfg_valid,
  input  logic [eng_cfg_pkg::CFG_W-1:0]     cfg_data,
  input  logic                              cfg_1x1,
  input  logic                              s_valid,
  input  eng_types_pkg::lanes_in_t          s_data,
  input  eng_types_pkg::beat_flags_t        s_flags,
  output logic                              m_valid,
  output eng_types_pkg::lanes_out_t         m_data,
  output logic                              m_is_max
);

  logic wr_step, wr_last;
  logic d_we, a_we, b_we;
  logic mode_1x1;

  logic [eng_cfg_pkg::ADDR_W-1:0] waddr, raddr;

  logic signed [eng_cfg_pkg::CFG_W-1:0] d_reg;
  eng_types_pkg::coef_t                 coef;
  eng_types_pkg::lanes_in_t             s_data_d;   // aligned with coef

  logic [eng_cfg_pkg::LATENCY-1:0] valid_pipe;
  eng_types_pkg::beat_flags_t      flag_pipe [eng_cfg_pkg::LATENCY];

  cfg_fsm cfg_fsm_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_valid (cfg_valid),
    .cfg_1x1   (cfg_1x1),
    .wr_last   (wr_last),
    .wr_step   (wr_step),
    .d_we      (d_we),
    .a_we      (a_we),
    .b_we      (b_we),
    .mode_1x1  (mode_1x1)
  );

  // shared by the A and B tables, restarts with each D word
  addr_counter wr_cnt_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .step     (wr_step),
    .clear    (d_we),
    .mode_1x1 (mode_1x1),
    .addr     (waddr),
    .last     (wr_last)
  );

  // channel index, one step per beat
  addr_counter rd_cnt_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .step     (s_valid),
    .clear    (d_we),
    .mode_1x1 (mode_1x1),
    .addr     (raddr),
    .last     ()
  );

  coef_ram a_ram_i (
    .clk   (clk),
    .we    (a_we),
    .waddr (waddr),
    .wdata (cfg_data),
    .re    (s_valid),
    .raddr (raddr),
    .rdata (coef.a)
  );

  coef_ram b_ram_i (
    .clk   (clk),
    .we    (b_we),
    .waddr (waddr),
    .wdata (cfg_data),
    .re    (s_valid),
    .raddr (raddr),
    .rdata (coef.b)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      d_reg <= '0;
    end else if (d_we) begin
      d_reg <= cfg_data;   // output bias
    end
  end

  // match the one cycle table read
  always_ff @(posedge clk) begin
    s_data_d <= s_data;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[eng_cfg_pkg::LATENCY-2:0], s_valid};
    end
  end

  always_ff @(posedge clk) begin
    flag_pipe[0] <= s_flags;
    for (int i = 1; i < eng_cfg_pkg::LATENCY; i++) begin
      flag_pipe[i] <= flag_pipe[i-1];
    end
  end

  for (genvar u = 0; u < eng_cfg_pkg::UNITS; u++) begin : g_lane
    lrelu_lane lane_i (
      .clk   (clk),
      .rst_n (rst_n),
      .x     (s_data_d[u]),
      .coef  (coef),
      .d     (d_reg),
      .lrelu (flag_pipe[1].is_lrelu),   // flag of the beat in stage 2
      .y     (m_data[u])
    );
  end

  assign m_valid  = valid_pipe[eng_cfg_pkg::LATENCY-1];
  assign m_is_max = flag_pipe[eng_cfg_pkg::LATENCY-1].is_max;

endmodule

/* logic/lrelu_lane.sv */
`timescale 1ns/1ps

module lrelu_lane (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic signed [eng_cfg_pkg::IN_W-1:0]  x,
  input  eng_types_pkg::coef_t              coef,
  input  logic signed [eng_cfg_pkg::CFG_W-1:0] d,
  input  logic                              lrelu,
  output logic [eng_cfg_pkg::OUT_W-1:0]     y
);

  localparam int PROD_W = eng_cfg_pkg::IN_W + eng_cfg_pkg::CFG_W;

  logic signed [PROD_W-1:0]             prod;
  logic signed [eng_cfg_pkg::ACC_W-1:0] prod_ext, b_ext, d_ext;
  logic signed [eng_cfg_pkg::ACC_W-1:0] acc1, acc2;
  logic signed [eng_cfg_pkg::ACC_W-1:0] leak_full, leaked;
  logic signed [eng_cfg_pkg::ACC_W-1:0] biased, shifted;
  logic [eng_cfg_pkg::ACC_W-eng_cfg_pkg::OUT_W:0] top_bits;
  logic fits;

  assign prod     = x * coef.a;
  assign prod_ext = {{(eng_cfg_pkg::ACC_W - PROD_W){prod[PROD_W-1]}}, prod};
  assign b_ext    = {{(eng_cfg_pkg::ACC_W - eng_cfg_pkg::CFG_W){coef.b[eng_cfg_pkg::CFG_W-1]}},
                     coef.b};
  assign d_ext    = {{(eng_cfg_pkg::ACC_W - eng_cfg_pkg::CFG_W){d[eng_cfg_pkg::CFG_W-1]}}, d};

  // p * 13 >>> 7
  assign leak_full = acc1 * eng_cfg_pkg::ALPHA_NUM;
  assign leaked    = leak_full >>> eng_cfg_pkg::ALPHA_SHIFT;

  assign biased  = acc2 + d_ext;
  assign shifted = biased >>> eng_cfg_pkg::OUT_SHIFT;

  // everything above the output sign bit must be a sign copy
  assign top_bits = shifted[eng_cfg_pkg::ACC_W-1:eng_cfg_pkg::OUT_W-1];
  assign fits     = (&top_bits) || !(|top_bits);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc1 <= '0;
      acc2 <= '0;
      y    <= '0;
    end else begin
      // stage 1, multiply-add
      acc1 <= prod_ext + b_ext;

      // stage 2, leak only negative sums
      if (lrelu && acc1[eng_cfg_pkg::ACC_W-1]) begin
        acc2 <= leaked;
      end else begin
        acc2 <= acc1;
      end

      // stage 3, bias, shift and clamp to -128..127
      if (fits) begin
        y <= shifted[eng_cfg_pkg::OUT_W-1:0];
      end else if (shifted[eng_cfg_pkg::ACC_W-1]) begin
        y <= {1'b1, {(eng_cfg_pkg::OUT_W-1){1'b0}}};
      end else begin
        y <= {1'b0, {(eng_cfg_pkg::OUT_W-1){1'b1}}};
      end
    end
  end

endmodule

/* logic/coef_ram.sv */
`timescale 1ns/1ps

module coef_ram (
  input  logic                           clk,
  input  logic                           we,
  input  logic [eng_cfg_pkg::ADDR_W-1:0] waddr,
  input  logic [eng_cfg_pkg::CFG_W-1:0]  wdata,
  input  logic                           re,
  input  logic [eng_cfg_pkg::ADDR_W-1:0] raddr,
  output logic [eng_cfg_pkg::CFG_W-1:0]  rdata
);

  // sized for the deeper 1x1 mode, 3x3 uses the first two entries
  logic [eng_cfg_pkg::CFG_W-1:0] mem [eng_cfg_pkg::DEPTH_1X1];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read, data follows re by one cycle
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= mem[raddr];
    end
  end

endmodule

/* logic/addr_counter.sv */
`timescale 1ns/1ps

module addr_counter (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           step,
  input  logic                           clear,
  input  logic                           mode_1x1,
  output logic [eng_cfg_pkg::ADDR_W-1:0] addr,
  output logic                           last
);

  logic [eng_cfg_pkg::ADDR_W-1:0] max_addr;

  // final index of the active table depth
  assign max_addr = mode_1x1 ? (eng_cfg_pkg::DEPTH_1X1 - 3'd1)
                             : (eng_cfg_pkg::DEPTH_3X3 - 3'd1);

  assign last = (addr == max_addr);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr <= '0;
    end else if (clear) begin
      addr <= '0;            // wins over step
    end else if (step) begin
      if (last) begin
        addr <= '0;
      end else begin
        addr <= addr + 1'b1;
      end
    end
  end

endmodule

/* logic/cfg_fsm.sv */
`timescale 1ns/1ps

module cfg_fsm (
  input  logic clk,
  input  logic rst_n,
  input  logic cfg_valid,
  input  logic cfg_1x1,
  input  logic wr_last,
  output logic wr_step,
  output logic d_we,
  output logic a_we,
  output logic b_we,
  output logic mode_1x1
);

  eng_types_pkg::cfg_sel_e state;

  // word order is D, then depth A words, then depth B words
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= eng_types_pkg::load_d;
      mode_1x1 <= 1'b1;
    end else if (cfg_valid) begin
      unique case (state)
        eng_types_pkg::load_d: begin
          state    <= eng_types_pkg::load_a;
          mode_1x1 <= cfg_1x1;   // depth is fixed for the whole load
        end
        eng_types_pkg::load_a: begin
          if (wr_last) begin
            state <= eng_types_pkg::load_b;
          end
        end
        eng_types_pkg::load_b: begin
          if (wr_last) begin
            state <= eng_types_pkg::load_d;
          end
        end
        default: begin
          state <= eng_types_pkg::load_d;
        end
      endcase
    end
  end

  // one strobe per word, decoded from the current target
  assign d_we = cfg_valid && (state == eng_types_pkg::load_d);
  assign a_we = cfg_valid && (state == eng_types_pkg::load_a);
  assign b_we = cfg_valid && (state == eng_types_pkg::load_b);

  // write address moves on table words only
  assign wr_step = a_we || b_we;

endmodule

/* logic/eng_types_pkg.sv */
package eng_types_pkg;

  // where the next configuration word goes
  typedef enum logic [1:0] {
    load_d = 2'd0,
    load_a = 2'd1,
    load_b = 2'd2
  } cfg_sel_e;

  typedef struct packed {
    logic is_max;     // passed through to m_is_max
    logic is_lrelu;   // enables the leak for negative sums
  } beat_flags_t;

  // one beat of signed input words, lane 0 in the low bits
  typedef logic signed [eng_cfg_pkg::UNITS-1:0][eng_cfg_pkg::IN_W-1:0] lanes_in_t;

  // one beat of saturated output bytes
  typedef logic [eng_cfg_pkg::UNITS-1:0][eng_cfg_pkg::OUT_W-1:0] lanes_out_t;

  // scale and bias for the current channel
  typedef struct packed {
    logic signed [eng_cfg_pkg::CFG_W-1:0] a;
    logic signed [eng_cfg_pkg::CFG_W-1:0] b;
  } coef_t;

endpackage

/* logic/eng_cfg_pkg.sv */
package eng_cfg_pkg;

  // lanes and word widths
  localparam int UNITS  = 4;
  localparam int IN_W   = 16;
  localparam int CFG_W  = 16;
  localparam int OUT_W  = 8;
  localparam int ACC_W  = 40;   // x*A+B plus headroom for the leak multiply

  // coefficient table sizing
  localparam int ADDR_W = 3;
  localparam logic [ADDR_W-1:0] DEPTH_1X1 = 3'd6;
  localparam logic [ADDR_W-1:0] DEPTH_3X3 = 3'd2;

  // leak factor ALPHA_NUM / 2**ALPHA_SHIFT, close to 0.1
  localparam logic signed [ACC_W-1:0] ALPHA_NUM = 40'sd13;
  localparam int ALPHA_SHIFT = 7;

  localparam int OUT_SHIFT = 8;  // drop fraction bits before saturating

  // s_valid edge to m_valid
  // one cycle for the table read, three in the lane
  localparam int LATENCY = 4;

endpackage
